//--- include/cps_main_consts.svh
// CPS-1 main CPU glue constants
// Region codes, I/O page register offsets and the idle bus value
`ifndef CPS_MAIN_CONSTS_SVH
`define CPS_MAIN_CONSTS_SVH

// Word address A[23:1]
`define CPS_ADDR_W 23

// A[23:20] value of the I/O page
`define CPS_IO_PAGE 4'h8

// A[23:18] prefix of video RAM
`define CPS_VRAM_HI 6'b1001_00

// I/O register offsets, taken from A[8:3]
`define CPS_IO_JOY    6'b00_0000
`define CPS_IO_SYS    6'b00_0011
`define CPS_IO_OLATCH 6'b00_0110
`define CPS_IO_SND0   6'b11_0000
`define CPS_IO_SND1   6'b11_0001

// Read value when nothing drives the bus
`define CPS_BUS_IDLE 16'hffff

`endif

//--- hdl/cps_main_pkg.sv
// CPS-1 main CPU glue types
// Target region, CPU write word views and I/O strobe bundle
`default_nettype none

package cps_main_pkg;

    typedef enum logic [2:0] {
        rgn_none,
        rgn_rom,
        rgn_ram,
        rgn_vram,
        rgn_io
    } cpu_region_e;

    // Same CPU write word, seen by the output latch and by the sound latches
    typedef union packed {
        struct packed {
            logic        ppu_rstn;
            logic [14:0] misc;
        } olatch;
        struct packed {
            logic [7:0]  unused_hi;
            logic [7:0]  cmd;
        } snd;
    } cpu_wdata_u;

    typedef struct packed {
        logic joy;
        logic sys;
        logic olatch;
        logic snd0;
        logic snd1;
        logic ppu1;
    } io_sel_t;

endpackage

`default_nettype wire

//--- hdl/cps_sel_if.sv
// CPS-1 decoded select bundle
// Carries the target region, the I/O strobes and the system register index
// from the address decoder to the register file and the acknowledge block
`timescale 1ns/1ps
`default_nettype none

interface cps_sel_if
    import cps_main_pkg::*;
();

    cpu_region_e region;
    io_sel_t     io;
    logic [1:0]  sys_idx;

    // Driven by the address decoder
    modport decode (
        output region,
        output io,
        output sys_idx
    );

    // Register file and DTACK block
    modport user (
        input region,
        input io,
        input sys_idx
    );

endinterface

`default_nettype wire

//--- hdl/cps_addr_decode.sv
// CPS-1 main CPU address decoder
// Classifies each bus cycle into ROM, work RAM, video RAM or I/O and
// raises the per-register strobes inside the I/O page
`timescale 1ns/1ps
`default_nettype none
`include "cps_main_consts.svh"

module cps_addr_decode
    import cps_main_pkg::*;
(
    input  logic [`CPS_ADDR_W:1] a,
    input  logic                 as_n,
    input  logic                 rnw,
    input  logic                 uds_n,
    input  logic                 lds_n,
    cps_sel_if.decode            sel
);

    logic       rom_hit;
    logic       ram_hit;
    logic       vram_hit;
    logic       io_hit;
    logic       uds_w;
    logic       lds_w;
    logic [5:0] io_off;

    assign io_off = a[8:3];
    assign uds_w  = ~rnw & ~uds_n;
    assign lds_w  = ~rnw & ~lds_n;

    assign rom_hit  = a[23:22] == 2'b00;
    assign ram_hit  = &a[23:18];
    // Top quarter of the VRAM window is not populated
    assign vram_hit = (a[23:18] == `CPS_VRAM_HI) && (a[17:16] != 2'b11);
    assign io_hit   = a[23:20] == `CPS_IO_PAGE;

    assign sel.sys_idx = a[2:1];

    always_comb begin
        sel.region = rgn_none;
        sel.io     = '0;
        if (!as_n) begin
            if (rom_hit) begin
                sel.region = rgn_rom;
            end else if (ram_hit) begin
                sel.region = rgn_ram;
            end else if (vram_hit) begin
                sel.region = rgn_vram;
            end else if (io_hit) begin
                sel.region = rgn_io;
            end

            if (io_hit) begin
                if (rnw) begin
                    // Cabinet inputs
                    sel.io.joy = io_off == `CPS_IO_JOY;
                    sel.io.sys = io_off == `CPS_IO_SYS;
                end else begin
                    sel.io.olatch = uds_w && (io_off == `CPS_IO_OLATCH);
                    sel.io.snd0   = lds_w && (io_off == `CPS_IO_SND0);
                    sel.io.snd1   = lds_w && (io_off == `CPS_IO_SND1);
                    sel.io.ppu1   = a[8:6] == 3'b100;
                end
            end
        end
    end

    // Memory map windows must never overlap
    region_onehot_a: assert property (
        @(negedge as_n) $onehot0({rom_hit, ram_hit, vram_hit, io_hit})
    );

endmodule

`default_nettype wire

//--- hdl/cps_io_regs.sv
// CPS-1 I/O register file
// Holds the PPU reset and sound command latches and captures the
// cabinet inputs and DIP switches for CPU reads
`timescale 1ns/1ps
`default_nettype none

module cps_io_regs
    import cps_main_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen10,
    cps_sel_if.user     sel,
    input  cpu_wdata_u  wdata,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        tilt,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  dipsw_c,
    output logic        ppu_rstn,
    output logic [7:0]  snd0_latch,
    output logic [7:0]  snd1_latch,
    output logic [15:0] sys_data
);

    // Output latches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ppu_rstn   <= 1'b0;
            snd0_latch <= 8'd0;
            snd1_latch <= 8'd0;
        end else if (cen10) begin
            if (sel.io.olatch) begin
                ppu_rstn <= wdata.olatch.ppu_rstn;
            end
            if (sel.io.snd0) begin
                snd0_latch <= wdata.snd.cmd;
            end
            if (sel.io.snd1) begin
                snd1_latch <= wdata.snd.cmd;
            end
        end
    end

    // Cabinet input capture, valid well before DTACK
    always_ff @(posedge clk) begin
        if (cen10) begin
            if (sel.io.joy) begin
                sys_data <= {joystick2, joystick1};
            end else if (sel.io.sys) begin
                case (sel.sys_idx)
                    2'd0: sys_data <= {tilt, dip_test, start_button, 1'b1,
                                       service, coin_input, 8'hff};
                    2'd1: sys_data <= {dipsw_a, 8'hff};
                    2'd2: sys_data <= {dipsw_b, 8'hff};
                    default: sys_data <= {dipsw_c, 8'hff};
                endcase
            end
        end
    end

    // Upper and lower byte latches live at distinct offsets
    latch_excl_a: assert property (
        @(posedge clk) disable iff (rst)
        !(sel.io.olatch && (sel.io.snd0 || sel.io.snd1))
    );

endmodule

`default_nettype wire

//--- hdl/cps_bus_ack.sv
// CPS-1 bus acknowledge and read return
// Drives the memory chip selects, multiplexes read data onto the CPU
// bus and generates DTACK once the addressed memory reports ok
`timescale 1ns/1ps
`default_nettype none
`include "cps_main_consts.svh"

module cps_bus_ack
    import cps_main_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen10,
    input  logic        cen10b,
    input  logic        as_n,
    input  logic        uds_w_n,
    input  logic        lds_w_n,
    cps_sel_if.user     sel,
    input  logic [15:0] sys_data,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic        rom_ok,
    input  logic        ram_ok,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        dtack_n,
    output logic [15:0] cpu_din
);

    logic ready;
    logic io_rdy;
    logic wr_idle_q;
    logic rom_sel;
    logic ram_sel;
    logic vram_sel;

    assign rom_sel  = sel.region == rgn_rom;
    assign ram_sel  = sel.region == rgn_ram;
    assign vram_sel = sel.region == rgn_vram;

    // Read return and readiness of the addressed target
    always_comb begin
        cpu_din = `CPS_BUS_IDLE;
        ready   = 1'b1;
        case (sel.region)
            rgn_rom: begin
                cpu_din = rom_data;
                ready   = rom_ok;
            end
            rgn_ram, rgn_vram: begin
                cpu_din = ram_data;
                ready   = ram_ok;
            end
            rgn_io: begin
                cpu_din = sys_data;
                ready   = io_rdy;
            end
            default: begin
                cpu_din = `CPS_BUS_IDLE;
                ready   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            wr_idle_q <= 1'b1;
            io_rdy    <= 1'b0;
            dtack_n   <= 1'b1;
        end else begin
            rom_cs  <= rom_sel;
            // Hold over while the write strobes are still idle
            ram_cs  <= ram_sel | (ram_cs & ~as_n & wr_idle_q);
            vram_cs <= vram_sel | (vram_cs & ~as_n & wr_idle_q);
            if (cen10) begin
                wr_idle_q <= uds_w_n & lds_w_n;
            end
            // I/O access is done once a cen10 step has seen it
            if (as_n) begin
                io_rdy <= 1'b0;
            end else if (cen10 && sel.region == rgn_io &&
                         (!(uds_w_n & lds_w_n) || sel.io.joy || sel.io.sys)) begin
                io_rdy <= 1'b1;
            end
            if (cen10b) begin
                if (as_n) begin
                    dtack_n <= 1'b1;
                end else if (ready) begin
                    dtack_n <= 1'b0;
                end
            end
        end
    end

    // DTACK released after the address strobe has gone
    dtack_release_a: assert property (
        @(posedge clk) disable iff (rst)
        (cen10b && as_n) |=> dtack_n
    );

endmodule

`default_nettype wire

//--- hdl/cps_irq_gen.sv
// CPS-1 vertical blank interrupt
// Requests level 1 on the start of vertical blank and drops the request
// on the CPU interrupt acknowledge cycle
`timescale 1ns/1ps
`default_nettype none

module cps_irq_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       dip_pause,
    input  logic       as_n,
    input  logic [2:0] fc,
    output logic       irq1_n,
    output logic       vpa_n
);

    logic last_lvbl;

    // Function code 7 marks an interrupt acknowledge, autovectored
    assign vpa_n = ~(&fc & ~as_n);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_lvbl <= 1'b1;
            irq1_n    <= 1'b1;
        end else begin
            last_lvbl <= lvbl;
            if (!vpa_n) begin
                irq1_n <= 1'b1;
            end else if (dip_pause && !lvbl && last_lvbl) begin
                // Pause switch low freezes the game loop
                irq1_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cps_main_bus.sv
// CPS-1 main CPU glue logic top level
// Connects the 68000 bus, the ROM and RAM controllers and the cabinet
// inputs to the decoder, register file, DTACK block and interrupt logic
`timescale 1ns/1ps
`default_nettype none
`include "cps_main_consts.svh"

module cps_main_bus (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen10,
    input  logic                 cen10b,
    // 68000 bus
    input  logic [`CPS_ADDR_W:1] a,
    input  logic                 as_n,
    input  logic                 rnw,
    input  logic                 uds_n,
    input  logic                 lds_n,
    input  logic [2:0]           fc,
    input  logic [15:0]          cpu_dout,
    output logic [15:0]          cpu_din,
    output logic                 dtack_n,
    output logic                 vpa_n,
    output logic                 irq1_n,
    // Video timing
    input  logic                 lvbl,
    // Latches
    output logic                 ppu_rstn,
    output logic [7:0]           snd0_latch,
    output logic [7:0]           snd1_latch,
    // Memories
    output logic                 uds_w_n,
    output logic                 lds_w_n,
    output logic [17:1]          addr,
    output logic [19:1]          rom_addr,
    output logic                 rom_cs,
    input  logic [15:0]          rom_data,
    input  logic                 rom_ok,
    output logic                 ram_cs,
    output logic                 vram_cs,
    input  logic [15:0]          ram_data,
    input  logic                 ram_ok,
    // Cabinet
    input  logic [7:0]           joystick1,
    input  logic [7:0]           joystick2,
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic                 service,
    input  logic                 tilt,
    // DIP switches
    input  logic                 dip_pause,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c
);

    logic [15:0] sys_data;

    cps_sel_if sel_bus ();

    assign uds_w_n  = rnw | uds_n;
    assign lds_w_n  = rnw | lds_n;
    assign addr     = a[17:1];
    assign rom_addr = a[19:1];

    cps_addr_decode u_decode (
        .a     (a),
        .as_n  (as_n),
        .rnw   (rnw),
        .uds_n (uds_n),
        .lds_n (lds_n),
        .sel   (sel_bus.decode)
    );

    cps_io_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .cen10        (cen10),
        .sel          (sel_bus.user),
        .wdata        (cpu_dout),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .tilt         (tilt),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .ppu_rstn     (ppu_rstn),
        .snd0_latch   (snd0_latch),
        .snd1_latch   (snd1_latch),
        .sys_data     (sys_data)
    );

    cps_bus_ack u_ack (
        .clk      (clk),
        .rst      (rst),
        .cen10    (cen10),
        .cen10b   (cen10b),
        .as_n     (as_n),
        .uds_w_n  (uds_w_n),
        .lds_w_n  (lds_w_n),
        .sel      (sel_bus.user),
        .sys_data (sys_data),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .vram_cs  (vram_cs),
        .dtack_n  (dtack_n),
        .cpu_din  (cpu_din)
    );

    cps_irq_gen u_irq (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .as_n      (as_n),
        .fc        (fc),
        .irq1_n    (irq1_n),
        .vpa_n     (vpa_n)
    );

endmodule

`default_nettype wire

//--- verif/cps_main_tb.sv
// CPS-1 main CPU glue testbench
// Plays the 68000 bus master against ROM and RAM models with random
// ok latency; concurrent assertions check every bus and latch result
`timescale 1ns/1ps
`default_nettype none
`include "cps_main_consts.svh"

module cps_main_tb;

    localparam int PERIOD      = 40;
    localparam int DTACK_LIMIT = 20;
    localparam int N_BUS       = 30;
    localparam int MAX_WAIT    = 5;
    localparam int CYC_OVH     = 8;
    localparam int MARGIN      = 100;

    logic        clk, rst, cen10, cen10b;
    logic [23:1] a;
    logic        as_n, rnw, uds_n, lds_n;
    logic [2:0]  fc;
    logic [15:0] cpu_dout;
    logic [15:0] cpu_din;
    logic        dtack_n, vpa_n, irq1_n, lvbl;
    logic        ppu_rstn;
    logic [7:0]  snd0_latch, snd1_latch;
    logic        uds_w_n, lds_w_n;
    logic [17:1] addr;
    logic [19:1] rom_addr;
    logic        rom_cs, rom_ok, ram_cs, vram_cs, ram_ok;
    logic [15:0] rom_data, ram_data;
    logic [7:0]  joystick1, joystick2;
    logic [1:0]  start_button, coin_input;
    logic        service, tilt, dip_pause, dip_test;
    logic [7:0]  dipsw_a, dipsw_b, dipsw_c;

    // Testbench state shared with the assertions
    logic [31:0] rng = 32'h2b51b053;
    string       tname = "reset";
    int          mism_errs = 0;
    int          other_errs = 0;
    int          rd_wait, rom_cnt, ram_cnt;
    logic [15:0] rd_exp, rd_got;
    logic [2:0]  cs_exp, cs_got;
    logic [1:0]  cur_rgn;
    logic        res_chk, chk_data, chk_prompt, dtack_seen;
    logic        lat_chk, exp_ppu, ram_wr, rst_chk;
    logic        irq_chk, irq_exp, ack_done, vpa_seen;
    logic        rom_busy, ram_busy, sel_ok;
    logic [7:0]  exp_snd0, exp_snd1;
    logic [21:0] reset_view;

    cps_main_bus dut0 (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory contents as a function of the whole byte address
    function automatic logic [15:0] rom_word(input logic [23:0] ba);
        return ba[16:1] ^ {ba[19:17], 13'h0a5c};
    endfunction

    function automatic logic [15:0] ram_word(input logic [23:0] ba);
        return {ba[8:1], ba[16:9]} ^ {ba[17], 15'h1e69};
    endfunction

    function automatic logic [23:0] io_byte(input logic [5:0] off, input logic [1:0] idx);
        return {4'h8, 11'd0, off, idx, 1'b0};
    endfunction

    assign rom_data   = rom_word({4'h0, rom_addr, 1'b0});
    assign ram_data   = ram_word({6'h0, addr, 1'b0});
    assign sel_ok     = (cur_rgn == 2'd1) ? rom_ok : (cur_rgn == 2'd2) ? ram_ok : 1'b1;
    assign reset_view = {dtack_n, irq1_n, ppu_rstn, rom_cs, ram_cs, vram_cs,
                         snd0_latch, snd1_latch};

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // One memory model step, ok follows cs after a random wait of 0 to 5
    task automatic step_mem(input logic cs, inout logic busy, inout int cnt, inout logic ok);
        if (cs !== 1'b1) begin
            busy = 1'b0;
            ok   = 1'b0;
        end else if (!busy) begin
            busy = 1'b1;
            rng  = xorshift32(rng);
            cnt  = rng % (MAX_WAIT + 1);
            ok   = (cnt == 0);
        end else if (cnt > 0) begin
            cnt = cnt - 1;
            ok  = (cnt == 0);
        end
    endtask

    task automatic bus_cycle(input logic [23:1] wa, input logic rd, input logic [15:0] wd);
        int n;
        n = 0;
        repeat (2) step();
        a        = wa;
        rnw      = rd;
        fc       = 3'd5;
        cpu_dout = wd;
        as_n     = 1'b0;
        uds_n    = ~rd;
        lds_n    = ~rd;
        step();
        // Write strobes trail the address strobe by one clock
        uds_n = 1'b0;
        lds_n = 1'b0;
        while (dtack_n && n < DTACK_LIMIT) begin
            step();
            n++;
        end
        dtack_seen = ~dtack_n;
        rd_got     = cpu_din;
        cs_got     = {rom_cs, ram_cs, vram_cs};
        rd_wait    = n;
        as_n       = 1'b1;
        uds_n      = 1'b1;
        lds_n      = 1'b1;
        rnw        = 1'b1;
    endtask

    task automatic pulse_result();
        res_chk = 1'b1;
        step();
        res_chk = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [23:0] badr,
                              input logic [15:0] exp, input logic [2:0] cs_e,
                              input logic [1:0] rgn, input logic prompt);
        tname      = name;
        rd_exp     = exp;
        cs_exp     = cs_e;
        cur_rgn    = rgn;
        chk_data   = 1'b1;
        chk_prompt = prompt;
        bus_cycle(badr[23:1], 1'b1, 16'h0000);
        cur_rgn = 2'd0;
        pulse_result();
    endtask

    task automatic write_word(input string name, input logic [23:0] badr, input logic [15:0] wd,
                              input logic [2:0] cs_e, input logic e_ppu,
                              input logic [7:0] e_snd0, input logic [7:0] e_snd1);
        tname      = name;
        lat_chk    = 1'b0;
        chk_data   = 1'b0;
        chk_prompt = 1'b0;
        cs_exp     = cs_e;
        cur_rgn    = (cs_e == 3'b000) ? 2'd0 : 2'd2;
        ram_wr     = (cs_e == 3'b010);
        bus_cycle(badr[23:1], 1'b0, wd);
        ram_wr   = 1'b0;
        cur_rgn  = 2'd0;
        exp_ppu  = e_ppu;
        exp_snd0 = e_snd0;
        exp_snd1 = e_snd1;
        lat_chk  = 1'b1;
        pulse_result();
    endtask

    task automatic irq_expect(input string name, input logic exp);
        tname   = name;
        irq_exp = exp;
        irq_chk = 1'b1;
        step();
        irq_chk = 1'b0;
    endtask

    // Autovectored interrupt acknowledge, ended by VPA
    task automatic ack_cycle();
        int n;
        n = 0;
        repeat (2) step();
        a     = {20'hfffff, 3'b001};
        rnw   = 1'b1;
        fc    = 3'd7;
        as_n  = 1'b0;
        uds_n = 1'b0;
        lds_n = 1'b0;
        while (vpa_n && n < DTACK_LIMIT) begin
            step();
            n++;
        end
        vpa_seen = ~vpa_n;
        repeat (2) step();
        as_n     = 1'b1;
        uds_n    = 1'b1;
        lds_n    = 1'b1;
        fc       = 3'd5;
        ack_done = 1'b1;
        step();
    endtask

    reset_a: assert property (@(posedge clk) rst_chk |-> reset_view == 22'h300000)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %h actual %h", tname, 22'h300000,
                     $sampled(reset_view));
        end

    data_a: assert property (@(posedge clk) res_chk && chk_data |-> rd_got == rd_exp)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %h actual %h", tname, rd_exp, rd_got);
        end

    cs_a: assert property (@(posedge clk) res_chk |-> cs_got == cs_exp)
        else begin
            mism_errs++;
            $display("Mismatch %s chip selects expected %b actual %b", tname, cs_exp, cs_got);
        end

    dtack_a: assert property (@(posedge clk) res_chk |-> dtack_seen)
        else begin
            other_errs++;
            $display("DTACK never came in test %s", tname);
        end

    prompt_a: assert property (@(posedge clk) res_chk && chk_prompt |-> rd_wait <= 2)
        else begin
            other_errs++;
            $display("DTACK was slow on the unmapped read in test %s", tname);
        end

    // DTACK may only fall once the selected memory reports ok
    ok_wait_a: assert property (@(posedge clk) disable iff (rst) $fell(dtack_n) |-> $past(sel_ok))
        else begin
            other_errs++;
            $display("DTACK fell before the memory ok in test %s", tname);
        end

    // Memory write strobes stay idle on reads and follow the data strobes on writes
    rd_strobe_a: assert property (@(posedge clk) disable iff (rst)
                                  rnw |-> uds_w_n && lds_w_n)
        else begin
            other_errs++;
            $display("Write strobe active during a read in test %s", tname);
        end

    wr_strobe_a: assert property (@(posedge clk) disable iff (rst)
                                  !rnw && !as_n && !uds_n && !lds_n |-> !uds_w_n && !lds_w_n)
        else begin
            other_errs++;
            $display("Write strobes missing during a write in test %s", tname);
        end

    snd0_a: assert property (@(posedge clk) lat_chk |-> snd0_latch == exp_snd0)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %h actual %h", tname, exp_snd0, $sampled(snd0_latch));
        end

    snd1_a: assert property (@(posedge clk) lat_chk |-> snd1_latch == exp_snd1)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %h actual %h", tname, exp_snd1, $sampled(snd1_latch));
        end

    ppu_a: assert property (@(posedge clk) lat_chk |-> ppu_rstn == exp_ppu)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %b actual %b", tname, exp_ppu, $sampled(ppu_rstn));
        end

    irq_a: assert property (@(posedge clk) irq_chk |-> irq1_n == irq_exp)
        else begin
            mism_errs++;
            $display("Mismatch %s expected %b actual %b", tname, irq_exp, $sampled(irq1_n));
        end

    vpa_a: assert property (@(posedge clk) irq_chk && ack_done |-> vpa_seen)
        else begin
            other_errs++;
            $display("VPA was not asserted during the interrupt acknowledge");
        end

    ram_hold_a: assert property (@(posedge clk) disable iff (rst) ram_wr |-> !$fell(ram_cs))
        else begin
            other_errs++;
            $display("RAM select dropped inside the write cycle of test %s", tname);
        end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        cen10  = 1'b0;
        cen10b = 1'b0;
        forever begin
            step();
            cen10  = ~cen10;
            cen10b = ~cen10;
        end
    end

    initial begin
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        rom_busy = 1'b0;
        ram_busy = 1'b0;
        rom_cnt  = 0;
        ram_cnt  = 0;
        forever begin
            step();
            step_mem(rom_cs, rom_busy, rom_cnt, rom_ok);
            step_mem(ram_cs | vram_cs, ram_busy, ram_cnt, ram_ok);
        end
    end

    initial begin
        #((N_BUS * (MAX_WAIT + CYC_OVH) + MARGIN) * PERIOD);
        $display("Watchdog timeout, the test sequence did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        {a, cpu_dout, fc} = '0;
        {as_n, rnw, uds_n, lds_n, lvbl} = 5'b11111;
        {dip_pause, dip_test, service, tilt} = 4'b0110;
        {joystick1, joystick2, start_button, coin_input} = {8'hd7, 8'h6e, 2'b10, 2'b01};
        {dipsw_a, dipsw_b, dipsw_c} = {8'h3c, 8'ha5, 8'h81};
        {res_chk, chk_data, chk_prompt, dtack_seen, lat_chk, ram_wr, rst_chk} = '0;
        {irq_chk, irq_exp, ack_done, vpa_seen, exp_ppu} = '0;
        {rd_exp, rd_got, cs_exp, cs_got, cur_rgn, exp_snd0, exp_snd1} = '0;
        rd_wait = 0;
        repeat (3) step();
        rst     = 1'b0;
        rst_chk = 1'b1;
        step();
        rst_chk = 1'b0;

        check_read("rom_low", 24'h012344, rom_word(24'h012344), 3'b100, 2'd1, 1'b0);
        check_read("rom_high", 24'h3ffffe, rom_word(24'h3ffffe), 3'b100, 2'd1, 1'b0);
        check_read("ram_a", 24'hff1230, ram_word(24'hff1230), 3'b010, 2'd2, 1'b0);
        check_read("ram_b", 24'hfc0002, ram_word(24'hfc0002), 3'b010, 2'd2, 1'b0);
        check_read("vram_a", 24'h900010, ram_word(24'h900010), 3'b001, 2'd2, 1'b0);
        check_read("vram_b", 24'h92fffe, ram_word(24'h92fffe), 3'b001, 2'd2, 1'b0);

        write_word("snd0_write", io_byte(`CPS_IO_SND0, 2'd0), 16'hbe42, 3'b000,
                   1'b0, 8'h42, 8'h00);
        write_word("snd1_write", io_byte(`CPS_IO_SND1, 2'd0), 16'h13c7, 3'b000,
                   1'b0, 8'h42, 8'hc7);
        write_word("olatch_set", io_byte(`CPS_IO_OLATCH, 2'd0), 16'h80ff, 3'b000,
                   1'b1, 8'h42, 8'hc7);
        write_word("olatch_clear", io_byte(`CPS_IO_OLATCH, 2'd0), 16'h7f00, 3'b000,
                   1'b0, 8'h42, 8'hc7);

        check_read("joy", io_byte(`CPS_IO_JOY, 2'd0), {joystick2, joystick1}, 3'b000,
                   2'd0, 1'b0);
        check_read("sys0", io_byte(`CPS_IO_SYS, 2'd0), {tilt, dip_test, start_button, 1'b1,
                   service, coin_input, 8'hff}, 3'b000, 2'd0, 1'b0);
        check_read("dip_a", io_byte(`CPS_IO_SYS, 2'd1), {dipsw_a, 8'hff}, 3'b000, 2'd0, 1'b0);
        check_read("dip_b", io_byte(`CPS_IO_SYS, 2'd2), {dipsw_b, 8'hff}, 3'b000, 2'd0, 1'b0);
        check_read("dip_c", io_byte(`CPS_IO_SYS, 2'd3), {dipsw_c, 8'hff}, 3'b000, 2'd0, 1'b0);
        check_read("unmapped", 24'ha00000, `CPS_BUS_IDLE, 3'b000, 2'd0, 1'b1);
        check_read("vram_gap", 24'h930000, `CPS_BUS_IDLE, 3'b000, 2'd0, 1'b1);

        write_word("ram_write", 24'hff2000, 16'h1234, 3'b010, 1'b0, 8'h42, 8'hc7);

        dip_pause = 1'b1;
        lvbl      = 1'b0;
        repeat (2) step();
        irq_expect("irq_vblank", 1'b0);
        lvbl = 1'b1;
        ack_cycle();
        irq_expect("irq_ack", 1'b1);
        ack_done  = 1'b0;
        dip_pause = 1'b0;
        lvbl      = 1'b0;
        repeat (2) step();
        irq_expect("irq_paused", 1'b1);
        lvbl = 1'b1;
        repeat (2) step();

        $display("Errors: %0d mismatches, %0d other failures", mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hdl/cps_main_pkg.sv
hdl/cps_sel_if.sv
hdl/cps_addr_decode.sv
hdl/cps_io_regs.sv
hdl/cps_bus_ack.sv
hdl/cps_irq_gen.sv
hdl/cps_main_bus.sv
verif/cps_main_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPS-1 main bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cps_main_tb \
    -Mdir obj_dir -o cps_main_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/cps_main_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
